/* video_pkg.sv */
`default_nettype none

package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Coordinate widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [10:0] pixel_coord_t;   // Screen counter or active coordinate
    typedef logic [7:0]  lcd_coord_t;     // Console pixel coordinate

    ////////////////////////////////////////////////////////////////////////////
    // Block to block bundles
    ////////////////////////////////////////////////////////////////////////////

    // Horizontal state, all fields registered in line_timer
    typedef struct packed {
        pixel_coord_t h_count;    // Pixel within line
        logic         hs;         // Active low
        logic         line_tick;  // Last cycle of hsync
        lcd_coord_t   col;        // Divided column
        logic         col_step;   // First pixel of a scaled column
    } line_state_t;

    // Vertical state, advances on line_tick only
    typedef struct packed {
        pixel_coord_t v_count;    // Line within frame
        logic         vs;         // Active low
        lcd_coord_t   row;        // Divided row
        logic         row_step;   // First line of a scaled row
    } frame_state_t;

    typedef struct packed {
        pixel_coord_t x;
        pixel_coord_t y;
        lcd_coord_t   win_x;
        lcd_coord_t   win_y;
        logic         win_en;     // Inside scaled window
        logic         win_grid;   // Scale boundary inside window
        logic         de;         // Active area, two cycles late
    } video_out_t;

endpackage

`default_nettype wire

/* line_timer.sv */
`default_nettype none

module line_timer #(
    parameter int H_FRONT = 26,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 38,
    parameter int H_ACT   = 640,
    parameter int SCALE   = 3,
    parameter int WIN_X0  = 80
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_sync,
    output video_pkg::line_state_t  line
);

    localparam int H_TOTAL = H_FRONT + H_SYNC + H_BACK + H_ACT;
    localparam int H_BLANK = H_FRONT + H_SYNC + H_BACK;
    localparam int PW      = (SCALE > 1) ? $clog2(SCALE) : 1;

    localparam video_pkg::pixel_coord_t H_LAST     = video_pkg::pixel_coord_t'(H_TOTAL - 1);
    localparam video_pkg::pixel_coord_t SYNC_START = video_pkg::pixel_coord_t'(H_FRONT);
    localparam video_pkg::pixel_coord_t SYNC_END   = video_pkg::pixel_coord_t'(H_FRONT + H_SYNC);
    localparam video_pkg::pixel_coord_t TICK_AT    = video_pkg::pixel_coord_t'(H_FRONT + H_SYNC - 1);
    localparam video_pkg::pixel_coord_t WIN_START  = video_pkg::pixel_coord_t'(H_BLANK + WIN_X0);
    localparam logic [PW-1:0]           PHASE_LAST = PW'(SCALE - 1);

    video_pkg::pixel_coord_t h_count;
    video_pkg::pixel_coord_t h_next;
    video_pkg::lcd_coord_t   col;
    video_pkg::lcd_coord_t   col_next;
    logic [PW-1:0]           phase;
    logic [PW-1:0]           phase_next;
    logic                    hs;
    logic                    line_tick;
    logic                    col_step;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        h_next = (h_count == H_LAST) ? '0 : h_count + 1'b1;

        // Divider realigns on the window's left edge every line
        if (h_next == WIN_START) begin
            phase_next = '0;
            col_next   = '0;
        end else if (phase == PHASE_LAST) begin
            phase_next = '0;
            col_next   = col + 1'b1;
        end else begin
            phase_next = phase + 1'b1;
            col_next   = col;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    // Flags are computed from h_next so they line up with h_count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_count   <= '0;
            hs        <= 1'b1;
            line_tick <= 1'b0;
            phase     <= '0;
            col       <= '0;
            col_step  <= 1'b0;
        end else if (frame_sync) begin   // Same as reset, but on the edge
            h_count   <= '0;
            hs        <= 1'b1;
            line_tick <= 1'b0;
            phase     <= '0;
            col       <= '0;
            col_step  <= 1'b0;
        end else begin
            h_count   <= h_next;
            hs        <= !((h_next >= SYNC_START) && (h_next < SYNC_END));
            line_tick <= (h_next == TICK_AT);   // Last hsync pixel
            phase     <= phase_next;
            col       <= col_next;
            col_step  <= (phase_next == '0);
        end
    end

    assign line.h_count   = h_count;
    assign line.hs        = hs;
    assign line.line_tick = line_tick;
    assign line.col       = col;
    assign line.col_step  = col_step;

endmodule

`default_nettype wire

/* frame_timer.sv */
`default_nettype none

module frame_timer #(
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33,
    parameter int V_ACT   = 480,
    parameter int SCALE   = 3,
    parameter int WIN_Y0  = 24
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_sync,
    input  video_pkg::line_state_t  line,
    output video_pkg::frame_state_t frame
);

    localparam int V_TOTAL = V_FRONT + V_SYNC + V_BACK + V_ACT;
    localparam int V_BLANK = V_FRONT + V_SYNC + V_BACK;
    localparam int PW      = (SCALE > 1) ? $clog2(SCALE) : 1;

    localparam video_pkg::pixel_coord_t V_LAST     = video_pkg::pixel_coord_t'(V_TOTAL - 1);
    localparam video_pkg::pixel_coord_t SYNC_START = video_pkg::pixel_coord_t'(V_FRONT);
    localparam video_pkg::pixel_coord_t SYNC_END   = video_pkg::pixel_coord_t'(V_FRONT + V_SYNC);
    localparam video_pkg::pixel_coord_t WIN_START  = video_pkg::pixel_coord_t'(V_BLANK + WIN_Y0);
    localparam logic [PW-1:0]           PHASE_LAST = PW'(SCALE - 1);

    video_pkg::pixel_coord_t v_count;
    video_pkg::pixel_coord_t v_next;
    video_pkg::lcd_coord_t   row;
    video_pkg::lcd_coord_t   row_next;
    logic [PW-1:0]           phase;
    logic [PW-1:0]           phase_next;
    logic                    vs;
    logic                    row_step;

    ////////////////////////////////////////////////////////////////////////////
    // Next state, one line ahead
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        v_next = (v_count == V_LAST) ? '0 : v_count + 1'b1;

        if (v_next == WIN_START) begin      // Top edge of the window
            phase_next = '0;
            row_next   = '0;
        end else if (phase == PHASE_LAST) begin
            phase_next = '0;
            row_next   = row + 1'b1;
        end else begin
            phase_next = phase + 1'b1;
            row_next   = row;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    // Line count moves mid blank, at the end of hsync
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            v_count  <= '0;
            vs       <= 1'b1;
            phase    <= '0;
            row      <= '0;
            row_step <= 1'b0;
        end else if (frame_sync) begin
            v_count  <= '0;
            vs       <= 1'b1;
            phase    <= '0;
            row      <= '0;
            row_step <= 1'b0;
        end else if (line.line_tick) begin
            v_count  <= v_next;
            vs       <= !((v_next >= SYNC_START) && (v_next < SYNC_END));
            phase    <= phase_next;
            row      <= row_next;
            row_step <= (phase_next == '0);
        end
    end

    assign frame.v_count  = v_count;
    assign frame.vs       = vs;
    assign frame.row      = row;
    assign frame.row_step = row_step;

endmodule

`default_nettype wire

/* window_mapper.sv */
`default_nettype none

module window_mapper #(
    parameter int H_BLANK = 160,
    parameter int V_BLANK = 45,
    parameter int SCALE   = 3,
    parameter int WIN_X0  = 80,
    parameter int WIN_Y0  = 24,
    parameter int WIN_W   = 160,
    parameter int WIN_H   = 144
) (
    input  logic                    clk,
    input  logic                    reset,
    input  video_pkg::line_state_t  line,
    input  video_pkg::frame_state_t frame,
    output video_pkg::video_out_t   video
);

    localparam video_pkg::pixel_coord_t H_START = video_pkg::pixel_coord_t'(H_BLANK);
    localparam video_pkg::pixel_coord_t V_START = video_pkg::pixel_coord_t'(V_BLANK);

    // Window bounds in active coordinates
    localparam video_pkg::pixel_coord_t X_LO = video_pkg::pixel_coord_t'(WIN_X0);
    localparam video_pkg::pixel_coord_t X_HI = video_pkg::pixel_coord_t'(WIN_X0 + SCALE * WIN_W);
    localparam video_pkg::pixel_coord_t Y_LO = video_pkg::pixel_coord_t'(WIN_Y0);
    localparam video_pkg::pixel_coord_t Y_HI = video_pkg::pixel_coord_t'(WIN_Y0 + SCALE * WIN_H);

    video_pkg::pixel_coord_t x;
    video_pkg::pixel_coord_t y;
    logic                    h_act;
    logic                    v_act;
    logic                    x_in;
    logic                    y_in;
    logic                    win_en;
    logic                    de_d1;
    logic                    de_d2;

    ////////////////////////////////////////////////////////////////////////////
    // Active coordinates
    ////////////////////////////////////////////////////////////////////////////

    assign h_act = (line.h_count >= H_START);
    assign v_act = (frame.v_count >= V_START);

    assign x = h_act ? (line.h_count - H_START) : '0;
    assign y = v_act ? (frame.v_count - V_START) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Scaled window
    ////////////////////////////////////////////////////////////////////////////

    // Active term keeps blanking out of the window when an origin is 0
    assign x_in   = h_act && (x >= X_LO) && (x < X_HI);
    assign y_in   = v_act && (y >= Y_LO) && (y < Y_HI);
    assign win_en = x_in && y_in;

    assign video.x        = x;
    assign video.y        = y;
    assign video.win_en   = win_en;
    assign video.win_x    = win_en ? line.col : '0;
    assign video.win_y    = y_in ? frame.row : '0;   // Valid for the whole line
    assign video.win_grid = win_en && (line.col_step || frame.row_step);

    ////////////////////////////////////////////////////////////////////////////
    // Pixel enable, two cycles behind the counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            de_d1 <= 1'b0;
            de_d2 <= 1'b0;
        end else begin
            de_d1 <= h_act && v_act;
            de_d2 <= de_d1;
        end
    end

    assign video.de = de_d2;

endmodule

`default_nettype wire

/* video_timing_top.sv */
`default_nettype none

module video_timing_top #(
    parameter int H_FRONT = 26,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 38,
    parameter int H_ACT   = 640,
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33,
    parameter int V_ACT   = 480,
    parameter int SCALE   = 3,
    parameter int WIN_X0  = 80,
    parameter int WIN_Y0  = 24,
    parameter int WIN_W   = 160,   // Console pixels
    parameter int WIN_H   = 144
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  frame_sync,
    output logic                  hs,
    output logic                  vs,
    output video_pkg::video_out_t video
);

    localparam int H_BLANK = H_FRONT + H_SYNC + H_BACK;
    localparam int V_BLANK = V_FRONT + V_SYNC + V_BACK;

    video_pkg::line_state_t  line_state;
    video_pkg::frame_state_t frame_state;

    line_timer #(
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .H_ACT   (H_ACT),
        .SCALE   (SCALE),
        .WIN_X0  (WIN_X0)
    ) line_timer_i (
        .clk        (clk),
        .reset      (reset),
        .frame_sync (frame_sync),
        .line       (line_state)
    );

    frame_timer #(
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .V_ACT   (V_ACT),
        .SCALE   (SCALE),
        .WIN_Y0  (WIN_Y0)
    ) frame_timer_i (
        .clk        (clk),
        .reset      (reset),
        .frame_sync (frame_sync),
        .line       (line_state),
        .frame      (frame_state)
    );

    window_mapper #(
        .H_BLANK (H_BLANK),
        .V_BLANK (V_BLANK),
        .SCALE   (SCALE),
        .WIN_X0  (WIN_X0),
        .WIN_Y0  (WIN_Y0),
        .WIN_W   (WIN_W),
        .WIN_H   (WIN_H)
    ) window_mapper_i (
        .clk   (clk),
        .reset (reset),
        .line  (line_state),
        .frame (frame_state),
        .video (video)
    );

    // Syncs leave straight from the timer registers
    assign hs = line_state.hs;
    assign vs = frame_state.vs;

endmodule

`default_nettype wire

/* tb_video_timing.sv */
`default_nettype none

module tb_video_timing;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 2;
    localparam int LIMIT_MARGIN = 100;
    localparam     TRACE_FILE   = "video_trace.txt";

    // Expected response at one sample point
    typedef struct packed {
        logic                  hs;
        logic                  vs;
        video_pkg::video_out_t video;
    } sample_t;

    logic                  clk;
    logic                  reset;
    logic                  frame_sync;
    logic                  hs;
    logic                  vs;
    video_pkg::video_out_t video;

    // Trace records, one entry per line of the file
    byte     rec_kind[$];
    int      rec_offset[$];
    string   rec_name[$];
    sample_t rec_expect[$];

    int mismatch_count = 0;
    int other_count    = 0;
    int cycle_limit    = 0;
    int edge_count     = 0;
    bit limit_ready    = 1'b0;
    bit sampled        = 1'b0;   // Current state already checked

    video_timing_top video_timing_top_i (
        .clk        (clk),
        .reset      (reset),
        .frame_sync (frame_sync),
        .hs         (hs),
        .vs         (vs),
        .video      (video)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_coord(input string name, input string field,
                               input video_pkg::pixel_coord_t expected,
                               input video_pkg::pixel_coord_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %0d, actual %0d", name, field, expected, actual);
        end
    endtask

    task automatic check_lcd(input string name, input string field,
                             input video_pkg::lcd_coord_t expected,
                             input video_pkg::lcd_coord_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %0d, actual %0d", name, field, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input string field,
                             input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %0d, actual %0d", name, field, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Trace loading
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_trace();
        int      fd;
        int      code;
        int      ch;
        int      offset;
        int      field [9];
        string   kind;
        string   name;
        sample_t expect_val;
        bit      done;
        int      samples;

        done    = 1'b0;
        samples = 0;
        foreach (field[i]) field[i] = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open trace file %s", TRACE_FILE);
            other_count++;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                done = 1'b1;                         // End of file
            end else if (kind.getc(0) == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)         // Skip rest of comment line
                    ch = $fgetc(fd);
            end else if (kind == "R" || kind == "S") begin
                code = $fscanf(fd, "%d %s", offset, name);
                if (code == 2 && kind == "S")
                    code += $fscanf(fd, "%d %d %d %d %d %d %d %d %d", field[0], field[1],
                                    field[2], field[3], field[4], field[5], field[6],
                                    field[7], field[8]);
                if (code != ((kind == "S") ? 11 : 2)) begin
                    $display("Trace record %0d has too few fields", rec_kind.size() + 1);
                    other_count++;
                    done = 1'b1;
                end else begin
                    expect_val.hs           = (field[0] != 0);
                    expect_val.vs           = (field[1] != 0);
                    expect_val.video.x      = video_pkg::pixel_coord_t'(field[2]);
                    expect_val.video.y      = video_pkg::pixel_coord_t'(field[3]);
                    expect_val.video.win_x  = video_pkg::lcd_coord_t'(field[4]);
                    expect_val.video.win_y  = video_pkg::lcd_coord_t'(field[5]);
                    expect_val.video.win_en = (field[6] != 0);
                    expect_val.video.win_grid = (field[7] != 0);
                    expect_val.video.de     = (field[8] != 0);
                    rec_kind.push_back(kind.getc(0));
                    rec_offset.push_back(offset);
                    rec_name.push_back(name);
                    rec_expect.push_back(expect_val);
                    if (kind == "S")
                        samples++;
                end
            end else begin
                $display("Trace holds an unknown record kind %s", kind);
                other_count++;
                done = 1'b1;
            end
        end
        if (fd != 0)
            $fclose(fd);
        if (fd != 0 && samples == 0) begin
            $display("Trace holds no sample records");
            other_count++;
        end
        // Run length follows the trace
        cycle_limit = LIMIT_MARGIN;
        for (int i = 0; i < rec_offset.size(); i++)
            cycle_limit += rec_offset[i];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Replay
    ////////////////////////////////////////////////////////////////////////////

    task automatic advance_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        sampled = 1'b0;
    endtask

    task automatic check_sample(input int idx);
        string   name;
        sample_t expected;

        name     = rec_name[idx];
        expected = rec_expect[idx];
        if (!sampled)
            #(CLK_PERIOD - 2 * DRIVE_DELAY);         // Just before the next edge
        sampled = 1'b1;
        check_bit(name, "hs", expected.hs, hs);
        check_bit(name, "vs", expected.vs, vs);
        check_coord(name, "x", expected.video.x, video.x);
        check_coord(name, "y", expected.video.y, video.y);
        check_lcd(name, "win_x", expected.video.win_x, video.win_x);
        check_lcd(name, "win_y", expected.video.win_y, video.win_y);
        check_bit(name, "win_en", expected.video.win_en, video.win_en);
        check_bit(name, "win_grid", expected.video.win_grid, video.win_grid);
        check_bit(name, "de", expected.video.de, video.de);
    endtask

    task automatic run_record(input int idx);
        repeat (rec_offset[idx]) advance_cycle();
        if (rec_kind[idx] == "R") begin
            frame_sync = 1'b1;
            advance_cycle();
            frame_sync = 1'b0;                       // Counters restart from here
        end else begin
            check_sample(idx);
        end
    endtask

    // Watchdog
    initial begin
        wait (limit_ready);
        while (edge_count < cycle_limit) begin
            @(posedge clk);
            edge_count++;
        end
        $display("Timeout after %0d cycles, trace replay did not finish", edge_count);
        $display("sim failed");
        $finish;
    end

    initial begin
        int idx;

        reset      = 1'b1;
        frame_sync = 1'b0;
        load_trace();
        limit_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;                                // State 0 of the first frame
        for (idx = 0; idx < rec_kind.size(); idx++)
            run_record(idx);

        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
video_pkg.sv
line_timer.sv
frame_timer.sv
window_mapper.sv
video_timing_top.sv
tb_video_timing.sv

/* Bender.yml */
package:
  name: video_timing

sources:
  # Design sources in compile order
  - files:
      - video_pkg.sv
      - line_timer.sv
      - frame_timer.sv
      - window_mapper.sv
      - video_timing_top.sv

  # Testbench, replays video_trace.txt from the project root
  - target: simulation
    files:
      - tb_video_timing.sv

/* video_trace.txt */
# kind offset name, S adds: hs vs x y win_x win_y win_en win_grid de
# offset is in clock cycles from the previous record, R pulses frame_sync
# Horizontal sync after reset
S 0 reset_state 1 1 0 0 0 0 0 0 0
S 25 h25_before_hsync 1 1 0 0 0 0 0 0 0
S 1 h26_hsync_low 0 1 0 0 0 0 0 0 0
S 95 h121_line_tick 0 1 0 0 0 0 0 0 0
S 1 h122_hsync_high 1 1 0 0 0 0 0 0 0
# Vertical sync on lines 10 and 11
S 7199 v9_h121 0 1 0 0 0 0 0 0 0
S 1 v10_h122_vsync_low 1 0 0 0 0 0 0 0 0
S 1178 v11_h500 1 0 340 0 0 0 0 0 0
S 421 v11_h121 0 0 0 0 0 0 0 0 0
S 1 v12_h122_vsync_high 1 1 0 0 0 0 0 0 0
# Active area entry and pixel enable
S 26437 v45_h159 1 1 0 0 0 0 0 0 0
S 1 active_entry 1 1 0 0 0 0 0 0 0
S 1 entry_plus1 1 1 1 0 0 0 0 0 0
S 1 de_rise 1 1 2 0 0 0 0 0 1
# Window top edge
S 18599 x201_y23 1 1 201 23 0 0 0 0 1
S 800 x201_y24 1 1 201 24 40 0 1 1 1
S 800 x201_y25 1 1 201 25 40 0 1 0 1
S 23760 v99_h121 0 1 0 54 0 10 0 0 0
S 1 v100_h122 1 1 0 55 0 10 0 0 0
# Window left and right edges on y 100
S 36117 x79_y100 1 1 79 100 0 25 0 0 1
S 1 x80_y100 1 1 80 100 0 25 1 1 1
S 1 x81_y100 1 1 81 100 0 25 1 0 1
S 1 x82_y100 1 1 82 100 0 25 1 0 1
S 1 x83_y100 1 1 83 100 1 25 1 1 1
S 476 x559_y100 1 1 559 100 159 25 1 0 1
S 1 x560_y100 1 1 560 100 0 25 0 0 1
S 180 hblank_y100 0 1 0 100 0 25 0 0 0
# Window bottom edge
S 281861 x201_y453 1 1 201 453 40 143 1 1 1
S 1600 x201_y455 1 1 201 455 40 143 1 0 1
S 800 x201_y456 1 1 201 456 0 0 0 0 1
# Far corner and frame wrap
S 18838 far_corner 1 1 639 479 0 0 0 0 1
S 1 corner_plus1 1 1 0 479 0 0 0 0 1
S 2 corner_plus3 1 1 0 479 0 0 0 0 0
S 119 v524_h121 0 1 0 479 0 0 0 0 0
S 1 frame_wrap 1 1 0 0 0 0 0 0 0
S 8078 frame2_v10 1 0 40 0 0 0 0 0 0
S 1459 frame2_v11_h59 0 0 0 0 0 0 0 0 0
# Resync in the middle of vertical sync
R 1 resync_pulse
S 0 resync_state 1 1 0 0 0 0 0 0 0
S 26 resync_h26 0 1 0 0 0 0 0 0 0
S 96 resync_h122 1 1 0 0 0 0 0 0 0
S 7278 resync_v10 1 0 40 0 0 0 0 0 0
S 108040 resync_x80_y100 1 1 80 100 0 25 1 1 1
